// File: logic/vic_defs.svh
`ifndef VIC_DEFS_SVH
`define VIC_DEFS_SVH

`define NUM_SPRITES 8

// display mode codes, {ecm,bmm,mcm}
`define MODE_STANDARD_CHAR                           3'd0
`define MODE_MULTICOLOR_CHAR                         3'd1
`define MODE_STANDARD_BITMAP                         3'd2
`define MODE_MULTICOLOR_BITMAP                       3'd3
`define MODE_EXTENDED_BG_COLOR                       3'd4
`define MODE_INV_EXTENDED_BG_COLOR_MULTICOLOR_CHAR   3'd5
`define MODE_INV_EXTENDED_BG_COLOR_STANDARD_BITMAP   3'd6
`define MODE_INV_EXTENDED_BG_COLOR_MULTICOLOR_BITMAP 3'd7

`define BLACK 4'd0

// register addresses
`define REG_CTRL1    6'h11
`define REG_CTRL2    6'h16
`define REG_SPR_PRI  6'h1B
`define REG_SPR_MMC  6'h1C
`define REG_EC       6'h20
`define REG_B0C      6'h21
`define REG_B1C      6'h22
`define REG_B2C      6'h23
`define REG_B3C      6'h24
`define REG_MM0      6'h25
`define REG_MM1      6'h26
// sprite colours follow from here, one per sprite
`define REG_SPR_COL0 6'h27

`endif

// File: logic/vic_pkg.sv
package vic_pkg;

    // palette index
    typedef logic [3:0] color_t;

    // fetched char word, colour nibble in 11:8 and screen code in 7:0
    typedef logic [11:0] char_word_t;

    // front sprite, bit 3 is valid and 2:0 the sprite index
    typedef logic [3:0] sprite_sel_t;

    // cycle within a raster line, 0 to 62
    typedef logic [6:0] cycle_num_t;

endpackage

// File: logic/dot_timing.sv
`timescale 1ns/1ps

module dot_timing (
    input  logic                clk_dot4x,
    input  logic                arst_n_i,
    output logic                dot_rising_1_o,
    output logic                dot_rising_3_o,
    output logic                clk_phi_o,
    output logic                phi_phase_start_pl_o,
    output logic                phi_phase_start_dav_o,
    output logic [2:0]          cycle_bit_o,
    output vic_pkg::cycle_num_t cycle_num_o
);

    logic [1:0] dot_phase;
    // phi strobes stay quiet until the first dot has begun
    logic       started;

    always_ff @(posedge clk_dot4x or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dot_phase   <= 2'd0;
            cycle_bit_o <= 3'd0;
            cycle_num_o <= '0;
            started     <= 1'b0;
        end else begin
            dot_phase <= dot_phase + 2'd1;
            if (dot_phase == 2'd1) begin
                started <= 1'b1;
            end
            if (dot_phase == 2'd3) begin
                cycle_bit_o <= cycle_bit_o + 3'd1;
                // line is 63 cycles long
                if (cycle_bit_o == 3'd7) begin
                    cycle_num_o <= (cycle_num_o == 7'd62) ? '0 : cycle_num_o + 7'd1;
                end
            end
        end
    end

    assign dot_rising_1_o        = dot_phase == 2'd1;
    assign dot_rising_3_o        = dot_phase == 2'd3;
    // phi high for the second half of the cycle
    assign clk_phi_o             = cycle_bit_o[2];
    assign phi_phase_start_pl_o  = started && dot_phase == 2'd0 && cycle_bit_o == 3'd0;
    assign phi_phase_start_dav_o = started && dot_phase == 2'd0 && cycle_bit_o == 3'd4;

    a_dot_strobes_apart: assert property (@(posedge clk_dot4x) disable iff (!arst_n_i)
        !(dot_rising_1_o && dot_rising_3_o))
        else $error("dot_rising_1 and dot_rising_3 high together");

endmodule

// File: logic/color_regs.sv
`timescale 1ns/1ps

`include "vic_defs.svh"

module color_regs (
    input  logic            clk_dot4x,
    input  logic            arst_n_i,
    input  logic            reg_we_i,
    input  logic [5:0]      reg_addr_i,
    input  logic [7:0]      reg_data_i,
    output logic            ecm_o,
    output logic            bmm_o,
    output logic            mcm_o,
    output logic [2:0]      xscroll_o,
    output vic_pkg::color_t ec_o,
    output vic_pkg::color_t b0c_o,
    output vic_pkg::color_t b1c_o,
    output vic_pkg::color_t b2c_o,
    output vic_pkg::color_t b3c_o,
    output vic_pkg::color_t mc0_o,
    output vic_pkg::color_t mc1_o,
    output logic [31:0]     spr_col_o,
    output logic [7:0]      spr_pri_o,
    output logic [7:0]      spr_mmc_o
);

    logic [5:0] spr_off;
    logic       spr_hit;

    assign spr_off = reg_addr_i - `REG_SPR_COL0;
    assign spr_hit = reg_addr_i >= `REG_SPR_COL0 && reg_addr_i < `REG_SPR_COL0 + 6'd8;

    always_ff @(posedge clk_dot4x or negedge arst_n_i) begin
        if (!arst_n_i) begin
            {ecm_o, bmm_o, mcm_o} <= '0;
            xscroll_o             <= 3'd0;
            {ec_o, b0c_o, b1c_o, b2c_o, b3c_o, mc0_o, mc1_o} <= '0;
            spr_col_o             <= '0;
            spr_pri_o             <= '0;
            spr_mmc_o             <= '0;
        end else if (reg_we_i) begin
            case (reg_addr_i)
                `REG_CTRL1: begin
                    ecm_o <= reg_data_i[6];
                    bmm_o <= reg_data_i[5];
                end
                `REG_CTRL2: begin
                    mcm_o     <= reg_data_i[4];
                    xscroll_o <= reg_data_i[2:0];
                end
                `REG_SPR_PRI: spr_pri_o <= reg_data_i;
                `REG_SPR_MMC: spr_mmc_o <= reg_data_i;
                `REG_EC:      ec_o      <= reg_data_i[3:0];
                `REG_B0C:     b0c_o     <= reg_data_i[3:0];
                `REG_B1C:     b1c_o     <= reg_data_i[3:0];
                `REG_B2C:     b2c_o     <= reg_data_i[3:0];
                `REG_B3C:     b3c_o     <= reg_data_i[3:0];
                `REG_MM0:     mc0_o     <= reg_data_i[3:0];
                `REG_MM1:     mc1_o     <= reg_data_i[3:0];
                default: begin
                    // sprite 0 sits in the top nibble
                    if (spr_hit) begin
                        spr_col_o[{3'd7 - spr_off[2:0], 2'b00} +: 4] <= reg_data_i[3:0];
                    end
                end
            endcase
        end
    end

endmodule

// File: logic/phase_delay.sv
`timescale 1ns/1ps

module phase_delay #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_dot4x,
    input  payload_t data_i,
    input  logic     capture_i,
    input  logic     transfer_i,
    output payload_t data_o
);

    payload_t stage_a;
    payload_t stage_b;

    always_ff @(posedge clk_dot4x) begin
        if (capture_i) begin
            stage_a <= data_i;
            stage_b <= stage_a;
        end
        // hand over so the data is ready when the shifter loads
        if (transfer_i) begin
            data_o <= stage_b;
        end
    end

endmodule

// File: logic/sprite_priority.sv
`timescale 1ns/1ps

`include "vic_defs.svh"

module sprite_priority (
    input  logic                 clk_dot4x,
    input  logic                 arst_n_i,
    input  logic                 stage0_i,
    input  logic [15:0]          sprite_pixels_i,
    input  logic [7:0]           spr_mmc_i,
    output vic_pkg::sprite_sel_t active_sprite_o,
    output logic [1:0]           active_pixel_o
);

    logic [1:0]              pair [`NUM_SPRITES];
    logic [`NUM_SPRITES-1:0] vis;
    logic                    sel_valid;
    logic [2:0]              sel_idx;

    // unpack the pairs, sprite 0 in the top bits
    always_comb begin
        for (int i = 0; i < `NUM_SPRITES; i++) begin
            pair[i] = sprite_pixels_i[2 * (`NUM_SPRITES - 1 - i) +: 2];
            // hires shows only on the high bit
            vis[i]  = spr_mmc_i[i] ? (pair[i] != 2'b00) : pair[i][1];
        end
    end

    // lowest numbered visible sprite wins
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = 3'd0;
        for (int i = `NUM_SPRITES - 1; i >= 0; i--) begin
            if (vis[i]) begin
                sel_valid = 1'b1;
                sel_idx   = 3'(i);
            end
        end
    end

    always_ff @(posedge clk_dot4x or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_sprite_o <= '0;
            active_pixel_o  <= 2'b00;
        end else if (stage0_i) begin
            active_sprite_o <= {sel_valid, sel_idx};
            active_pixel_o  <= sel_valid ? pair[sel_idx] : 2'b00;
        end
    end

    a_valid_has_pixel: assert property (@(posedge clk_dot4x) disable iff (!arst_n_i)
        (stage0_i && sel_valid) |=> (active_sprite_o[3] && active_pixel_o != 2'b00))
        else $error("active sprite flagged valid without a visible pixel");

endmodule

// File: logic/pixel_sequencer.sv
`timescale 1ns/1ps

`include "vic_defs.svh"

module pixel_sequencer (
    input  logic                 clk_dot4x,
    input  logic                 arst_n_i,
    input  logic                 dot_rising_1_i,
    input  logic                 dot_rising_3_i,
    input  logic [2:0]           cycle_bit_i,
    input  vic_pkg::cycle_num_t  cycle_num_i,
    input  vic_pkg::cycle_num_t  cycle_num_d_i,
    input  logic                 clk_phi_i,
    input  logic                 phi_phase_start_pl_i,
    input  logic                 mcm_i,
    input  logic                 bmm_i,
    input  logic                 ecm_i,
    input  logic                 idle_i,
    input  logic                 vborder_i,
    input  logic                 main_border_i,
    input  logic [2:0]           xscroll_i,
    input  logic [7:0]           pixels_d_i,
    input  vic_pkg::char_word_t  char_d_i,
    input  vic_pkg::color_t      b0c_i,
    input  vic_pkg::color_t      b1c_i,
    input  vic_pkg::color_t      b2c_i,
    input  vic_pkg::color_t      b3c_i,
    input  vic_pkg::color_t      ec_i,
    input  vic_pkg::color_t      mc0_i,
    input  vic_pkg::color_t      mc1_i,
    input  logic [31:0]          spr_col_i,
    input  logic [7:0]           spr_pri_i,
    input  logic [7:0]           spr_mmc_i,
    input  vic_pkg::sprite_sel_t active_sprite_i,
    input  logic [1:0]           active_pixel_i,
    output logic                 stage0_o,
    output vic_pkg::color_t      pixel_color_o,
    output logic                 pixel_strobe_o
);

    logic                stage1;
    logic [2:0]          xscroll_d;
    logic                mcm_d, bmm_d, ecm_d, mcm_d_prev, g_mc_ff;
    logic                mcm_n, bmm_n, ecm_n, mcm_prev_n, mc_ff_n;
    logic                visible, visible_d, load, load_data;
    logic [7:0]          shift_src, pixels_shifting;
    vic_pkg::char_word_t char_src, char_shifting;
    logic [1:0]          pair_n;
    logic                bg_n, is_bg0, is_bg1, main_border_stage1;
    // {ecm,bmm,mcm,px1,px0}, not a colour
    logic [4:0]          pixel_value;
    vic_pkg::color_t     b0c_d, b1c_d, b2c_d, b3c_d, ec_d;
    vic_pkg::color_t     mc0_d1, mc0_d2, mc1_d1, mc1_d2;
    logic [31:0]         spr_col_d1, spr_col_d2;
    logic [2:0]          spr_idx;
    vic_pkg::color_t     spr_color, pixel_color1, pixel_color2;

    assign visible   = cycle_num_i >= 7'd15 && cycle_num_i <= 7'd54;
    assign visible_d = cycle_num_d_i >= 7'd15 && cycle_num_d_i <= 7'd54;
    assign load      = xscroll_d == cycle_bit_i;
    assign load_data = load && visible_d && !vborder_i;

    // mode bits and mc flip-flop as they stand for this dot
    always_comb begin
        mcm_n      = (cycle_bit_i == 3'd4) ? mcm_i : mcm_d;
        bmm_n      = bmm_d;
        ecm_n      = ecm_d;
        if (cycle_bit_i == 3'd4) begin
            bmm_n = bmm_d | bmm_i;
            ecm_n = ecm_d | ecm_i;
        end else if (cycle_bit_i == 3'd6) begin
            bmm_n = bmm_d & bmm_i;
            ecm_n = ecm_d & ecm_i;
        end
        mcm_prev_n = (cycle_bit_i == 3'd7) ? mcm_d : mcm_d_prev;
        mc_ff_n    = g_mc_ff;
        if (cycle_bit_i == 3'd7 && mcm_d && !mcm_d_prev) begin
            mc_ff_n = 1'b0;
        end
        if (load) begin
            mc_ff_n = 1'b1;
        end
    end

    // shifter source and pixel pair
    always_comb begin
        shift_src = load ? (load_data ? pixels_d_i : 8'h00) : pixels_shifting;
        char_src  = char_shifting;
        if (load_data) begin
            char_src = idle_i ? '0 : char_d_i;
        end
        pair_n = shift_src[7] ? 2'b11 : 2'b00;
        bg_n   = !shift_src[7];
        if (bmm_n || char_src[11]) begin
            if (!mcm_prev_n) begin
                pair_n = {shift_src[7], 1'b0};
            end else if (mc_ff_n) begin
                pair_n = shift_src[7:6];
            end else begin
                // second half of a multicolour pair
                pair_n = pixel_value[1:0];
                bg_n   = is_bg0;
            end
        end
    end

    always_ff @(posedge clk_dot4x or negedge arst_n_i) begin
        if (!arst_n_i) begin
            {stage0_o, stage1, pixel_strobe_o} <= '0;
            pixel_color_o <= '0;
            xscroll_d     <= 3'd0;
            {mcm_d, bmm_d, ecm_d, mcm_d_prev, g_mc_ff} <= '0;
        end else begin
            stage0_o       <= dot_rising_1_i;
            stage1         <= stage0_o;
            pixel_strobe_o <= stage1;
            if (stage1) begin
                pixel_color_o <= main_border_stage1 ? ec_d : pixel_color2;
            end
            if (!clk_phi_i && phi_phase_start_pl_i && visible && !vborder_i) begin
                xscroll_d <= xscroll_i;
            end
            if (dot_rising_1_i) begin
                {mcm_d, bmm_d, ecm_d, mcm_d_prev} <= {mcm_n, bmm_n, ecm_n, mcm_prev_n};
                g_mc_ff <= mc_ff_n;
            end else if (dot_rising_3_i) begin
                g_mc_ff <= ~g_mc_ff;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (dot_rising_1_i) begin
            pixel_value     <= {ecm_n, bmm_n, mcm_n, pair_n};
            is_bg0          <= bg_n;
            pixels_shifting <= {shift_src[6:0], 1'b0};
            char_shifting   <= char_src;
        end
        if (stage0_o) begin
            {b0c_d, b1c_d, b2c_d, b3c_d} <= {b0c_i, b1c_i, b2c_i, b3c_i};
            // sprite colours lag one more pixel
            spr_col_d1         <= spr_col_i;
            spr_col_d2         <= spr_col_d1;
            {mc0_d1, mc1_d1}   <= {mc0_i, mc1_i};
            {mc0_d2, mc1_d2}   <= {mc0_d1, mc1_d1};
            is_bg1             <= is_bg0;
            main_border_stage1 <= main_border_i;
            case (pixel_value[4:2])
                `MODE_STANDARD_CHAR:
                    pixel_color1 <= pixel_value[1] ? char_shifting[11:8] : b0c_d;
                `MODE_MULTICOLOR_CHAR: begin
                    if (char_shifting[11]) begin
                        case (pixel_value[1:0])
                            2'b00:   pixel_color1 <= b0c_d;
                            2'b01:   pixel_color1 <= b1c_d;
                            2'b10:   pixel_color1 <= b2c_d;
                            default: pixel_color1 <= {1'b0, char_shifting[10:8]};
                        endcase
                    end else begin
                        pixel_color1 <= pixel_value[1] ? {1'b0, char_shifting[10:8]} : b0c_d;
                    end
                end
                `MODE_STANDARD_BITMAP:
                    pixel_color1 <= pixel_value[1] ? char_shifting[7:4] : char_shifting[3:0];
                `MODE_MULTICOLOR_BITMAP: begin
                    case (pixel_value[1:0])
                        2'b00:   pixel_color1 <= b0c_d;
                        2'b01:   pixel_color1 <= char_shifting[7:4];
                        2'b10:   pixel_color1 <= char_shifting[3:0];
                        default: pixel_color1 <= char_shifting[11:8];
                    endcase
                end
                `MODE_EXTENDED_BG_COLOR: begin
                    case ({pixel_value[1], char_shifting[7:6]})
                        3'b000:  pixel_color1 <= b0c_d;
                        3'b001:  pixel_color1 <= b1c_d;
                        3'b010:  pixel_color1 <= b2c_d;
                        3'b011:  pixel_color1 <= b3c_d;
                        default: pixel_color1 <= char_shifting[11:8];
                    endcase
                end
                // the three illegal modes
                default: pixel_color1 <= `BLACK;
            endcase
        end
        if (stage1) begin
            ec_d <= ec_i;
        end
    end

    // sprite overlay, the sprite selection is valid on stage1
    assign spr_idx   = active_sprite_i[2:0];
    assign spr_color = spr_col_d2[{3'd7 - spr_idx, 2'b00} +: 4];

    always_comb begin
        pixel_color2 = pixel_color1;
        if (active_sprite_i[3] && (!spr_pri_i[spr_idx] || is_bg1)) begin
            if (spr_mmc_i[spr_idx]) begin
                case (active_pixel_i)
                    2'b01:   pixel_color2 = mc0_d2;
                    2'b10:   pixel_color2 = spr_color;
                    2'b11:   pixel_color2 = mc1_d2;
                    default: pixel_color2 = pixel_color1;
                endcase
            end else if (active_pixel_i[1]) begin
                pixel_color2 = spr_color;
            end
        end
    end

    a_stage_order: assert property (@(posedge clk_dot4x) disable iff (!arst_n_i)
        stage0_o |=> stage1)
        else $error("stage1 did not follow stage0");

endmodule

// File: logic/vic_pixel_top.sv
`timescale 1ns/1ps

module vic_pixel_top (
    input  logic                clk_dot4x,
    input  logic                arst_n_i,
    input  logic                reg_we_i,
    input  logic [5:0]          reg_addr_i,
    input  logic [7:0]          reg_data_i,
    input  logic [7:0]          pixels_read_i,
    input  vic_pkg::char_word_t char_read_i,
    input  logic                idle_i,
    input  logic                vborder_i,
    input  logic                main_border_i,
    input  logic [15:0]         sprite_pixels_i,
    output vic_pkg::color_t     pixel_color_o,
    output logic                pixel_strobe_o,
    output vic_pkg::cycle_num_t cycle_num_o,
    output logic [2:0]          cycle_bit_o
);

    logic                 dot_rising_1, dot_rising_3, clk_phi, phi_start_pl, phi_start_dav;
    logic                 ecm, bmm, mcm, stage0;
    logic [2:0]           xscroll;
    vic_pkg::color_t      ec, b0c, b1c, b2c, b3c, mc0, mc1;
    logic [31:0]          spr_col;
    logic [7:0]           spr_pri, spr_mmc, pixels_d;
    vic_pkg::char_word_t  char_d;
    vic_pkg::cycle_num_t  cycle_num_d;
    vic_pkg::sprite_sel_t active_sprite;
    logic [1:0]           active_pixel;

    dot_timing u_timing (
        .clk_dot4x(clk_dot4x), .arst_n_i(arst_n_i),
        .dot_rising_1_o(dot_rising_1), .dot_rising_3_o(dot_rising_3), .clk_phi_o(clk_phi),
        .phi_phase_start_pl_o(phi_start_pl), .phi_phase_start_dav_o(phi_start_dav),
        .cycle_bit_o(cycle_bit_o), .cycle_num_o(cycle_num_o)
    );

    color_regs u_regs (
        .clk_dot4x(clk_dot4x), .arst_n_i(arst_n_i),
        .reg_we_i(reg_we_i), .reg_addr_i(reg_addr_i), .reg_data_i(reg_data_i),
        .ecm_o(ecm), .bmm_o(bmm), .mcm_o(mcm), .xscroll_o(xscroll),
        .ec_o(ec), .b0c_o(b0c), .b1c_o(b1c), .b2c_o(b2c), .b3c_o(b3c),
        .mc0_o(mc0), .mc1_o(mc1),
        .spr_col_o(spr_col), .spr_pri_o(spr_pri), .spr_mmc_o(spr_mmc)
    );

    // transfer only in the first half of phi
    phase_delay #(.payload_t(logic [7:0])) u_pixels_delay (
        .clk_dot4x(clk_dot4x), .data_i(pixels_read_i), .capture_i(phi_start_dav),
        .transfer_i(phi_start_pl & ~clk_phi), .data_o(pixels_d)
    );

    phase_delay #(.payload_t(vic_pkg::char_word_t)) u_char_delay (
        .clk_dot4x(clk_dot4x), .data_i(char_read_i), .capture_i(phi_start_dav),
        .transfer_i(phi_start_pl & ~clk_phi), .data_o(char_d)
    );

    phase_delay #(.payload_t(vic_pkg::cycle_num_t)) u_cycle_delay (
        .clk_dot4x(clk_dot4x), .data_i(cycle_num_o), .capture_i(phi_start_dav),
        .transfer_i(phi_start_pl & ~clk_phi), .data_o(cycle_num_d)
    );

    sprite_priority u_spr_pri (
        .clk_dot4x(clk_dot4x), .arst_n_i(arst_n_i), .stage0_i(stage0),
        .sprite_pixels_i(sprite_pixels_i), .spr_mmc_i(spr_mmc),
        .active_sprite_o(active_sprite), .active_pixel_o(active_pixel)
    );

    pixel_sequencer u_seq (
        .clk_dot4x(clk_dot4x), .arst_n_i(arst_n_i),
        .dot_rising_1_i(dot_rising_1), .dot_rising_3_i(dot_rising_3),
        .cycle_bit_i(cycle_bit_o), .cycle_num_i(cycle_num_o), .cycle_num_d_i(cycle_num_d),
        .clk_phi_i(clk_phi), .phi_phase_start_pl_i(phi_start_pl),
        .mcm_i(mcm), .bmm_i(bmm), .ecm_i(ecm), .idle_i(idle_i),
        .vborder_i(vborder_i), .main_border_i(main_border_i), .xscroll_i(xscroll),
        .pixels_d_i(pixels_d), .char_d_i(char_d),
        .b0c_i(b0c), .b1c_i(b1c), .b2c_i(b2c), .b3c_i(b3c), .ec_i(ec),
        .mc0_i(mc0), .mc1_i(mc1),
        .spr_col_i(spr_col), .spr_pri_i(spr_pri), .spr_mmc_i(spr_mmc),
        .active_sprite_i(active_sprite), .active_pixel_i(active_pixel),
        .stage0_o(stage0), .pixel_color_o(pixel_color_o), .pixel_strobe_o(pixel_strobe_o)
    );

endmodule

// File: tests/tb_vic_pixel.sv
`timescale 1ns/1ps

`include "vic_defs.svh"

module tb_vic_pixel;

    localparam int TIMEOUT_CLOCKS = 200000;

    logic                clk_dot4x;
    logic                arst_n_i;
    logic                reg_we;
    logic [5:0]          reg_addr;
    logic [7:0]          reg_data;
    logic [7:0]          pixels_read;
    vic_pkg::char_word_t char_read;
    logic                idle;
    logic                vborder;
    logic                main_border;
    logic [15:0]         sprite_pixels;
    vic_pkg::color_t     pixel_color;
    logic                pixel_strobe;
    vic_pkg::cycle_num_t cycle_num;
    logic [2:0]          cycle_bit;
    logic                in_window;
    logic [2:0]          exp_bit;
    vic_pkg::cycle_num_t exp_cycle;

    // register values as the testbench wrote them
    vic_pkg::color_t     ec_col, mm0_col, mm1_col;
    vic_pkg::color_t     bg_col [4];
    vic_pkg::color_t     spr_col [8];
    vic_pkg::char_word_t char_w;

    integer              seed = 32'h9e26_429a;
    int                  errors = 0;
    int                  checks = 0;
    int                  clocks_after_reset;
    logic                check_en = 1'b0;
    vic_pkg::color_t     exp_color = 4'd0;
    string               test_name = "reset";

    vic_pixel_top dut (
        .clk_dot4x(clk_dot4x), .arst_n_i(arst_n_i),
        .reg_we_i(reg_we), .reg_addr_i(reg_addr), .reg_data_i(reg_data),
        .pixels_read_i(pixels_read), .char_read_i(char_read), .idle_i(idle),
        .vborder_i(vborder), .main_border_i(main_border), .sprite_pixels_i(sprite_pixels),
        .pixel_color_o(pixel_color), .pixel_strobe_o(pixel_strobe),
        .cycle_num_o(cycle_num), .cycle_bit_o(cycle_bit)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #5 clk_dot4x = ~clk_dot4x;
    end

    // only the middle of the visible line is compared
    assign in_window = cycle_num >= 7'd20 && cycle_num <= 7'd50;

    // a dot is 4 clocks, a cycle 8 dots and a line 63 cycles, all counted from reset
    assign exp_bit   = 3'((clocks_after_reset / 4) % 8);
    assign exp_cycle = 7'((clocks_after_reset / 32) % 63);

    always @(posedge clk_dot4x or negedge arst_n_i) begin
        if (!arst_n_i) begin
            clocks_after_reset <= 0;
        end else begin
            clocks_after_reset <= clocks_after_reset + 1;
        end
    end

    always @(posedge clk_dot4x) begin
        if (check_en && pixel_strobe && in_window) begin
            checks <= checks + 1;
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk_dot4x)
        (arst_n_i && clocks_after_reset < 4) |-> (!pixel_strobe && pixel_color == 4'd0))
        else begin
            errors++;
            $display("FAILED after reset: expected strobe 0 colour 0, actual strobe %0b colour %0h",
                $sampled(pixel_strobe), $sampled(pixel_color));
        end

    a_cycle_position: assert property (@(posedge clk_dot4x)
        arst_n_i |-> (cycle_bit == exp_bit && cycle_num == exp_cycle))
        else begin
            errors++;
            $display("FAILED cycle_position: expected cycle %0d bit %0d, actual cycle %0d bit %0d",
                $sampled(exp_cycle), $sampled(exp_bit), $sampled(cycle_num), $sampled(cycle_bit));
        end

    a_pixel_colour: assert property (@(posedge clk_dot4x)
        (check_en && pixel_strobe && in_window) |-> (pixel_color == exp_color))
        else begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h",
                test_name, exp_color, $sampled(pixel_color));
        end

    function automatic vic_pkg::color_t rand_color();
        int r;
        r = $random(seed);
        return r[3:0];
    endfunction

    // sprite 0 occupies the top pair
    function automatic logic [15:0] sprite_pair(input int idx, input logic [1:0] px);
        logic [15:0] v;
        v = '0;
        v[2 * (7 - idx) +: 2] = px;
        return v;
    endfunction

    task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
        @(negedge clk_dot4x);
        reg_we   = 1'b1;
        reg_addr = addr;
        reg_data = data;
        @(negedge clk_dot4x);
        reg_we   = 1'b0;
    endtask

    task automatic set_mode(input logic ecm, input logic bmm, input logic mcm);
        write_reg(`REG_CTRL1, {1'b0, ecm, bmm, 5'd0});
        // xscroll stays 0
        write_reg(`REG_CTRL2, {3'd0, mcm, 4'd0});
    endtask

    task automatic set_pattern(input logic [7:0] px, input vic_pkg::char_word_t ch,
                               input logic [15:0] spr);
        @(negedge clk_dot4x);
        pixels_read   = px;
        char_read     = ch;
        sprite_pixels = spr;
    endtask

    task automatic wait_cycle(input logic [6:0] target);
        int n;
        n = 0;
        while (cycle_num != target && n < TIMEOUT_CLOCKS) begin
            @(negedge clk_dot4x);
            n++;
        end
        if (cycle_num != target) begin
            $display("timeout in %s while waiting for cycle %0d", test_name, target);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    task automatic wait_line_start();
        wait_cycle(7'd62);
        wait_cycle(7'd0);
    endtask

    // settle for a line, then compare for one whole line
    task automatic check_pattern(input string name, input vic_pkg::color_t expected);
        test_name = name;
        exp_color = expected;
        wait_line_start();
        wait_line_start();
        check_en = 1'b1;
        wait_line_start();
        check_en = 1'b0;
    endtask

    initial begin
        int r;
        reg_we        = 1'b0;
        reg_addr      = 6'd0;
        reg_data      = 8'd0;
        pixels_read   = 8'd0;
        char_read     = '0;
        idle          = 1'b0;
        vborder       = 1'b0;
        main_border   = 1'b0;
        sprite_pixels = 16'd0;
        arst_n_i      = 1'b0;
        repeat (4) @(negedge clk_dot4x);
        arst_n_i = 1'b1;

        ec_col  = rand_color();
        mm0_col = rand_color();
        mm1_col = rand_color();
        for (int i = 0; i < 4; i++) begin
            bg_col[i] = rand_color();
        end
        for (int i = 0; i < 8; i++) begin
            spr_col[i] = rand_color();
        end
        r      = $random(seed);
        char_w = r[11:0];

        write_reg(`REG_EC, {4'd0, ec_col});
        write_reg(`REG_MM0, {4'd0, mm0_col});
        write_reg(`REG_MM1, {4'd0, mm1_col});
        for (int i = 0; i < 4; i++) begin
            write_reg(`REG_B0C + i[5:0], {4'd0, bg_col[i]});
        end
        for (int i = 0; i < 8; i++) begin
            write_reg(`REG_SPR_COL0 + i[5:0], {4'd0, spr_col[i]});
        end

        main_border = 1'b1;
        set_mode(1'b0, 1'b1, 1'b0);
        set_pattern(8'h5A, char_w, 16'd0);
        check_pattern("border", ec_col);
        main_border = 1'b0;

        set_mode(1'b0, 1'b0, 1'b0);
        set_pattern(8'hFF, char_w, 16'd0);
        check_pattern("char_fg", char_w[11:8]);
        set_pattern(8'h00, char_w, 16'd0);
        check_pattern("char_bg", bg_col[0]);
        idle = 1'b1;
        set_pattern(8'hFF, char_w, 16'd0);
        check_pattern("char_idle", `BLACK);
        idle = 1'b0;

        set_mode(1'b0, 1'b1, 1'b0);
        set_pattern(8'hFF, char_w, 16'd0);
        check_pattern("bitmap_fg", char_w[7:4]);
        set_pattern(8'h00, char_w, 16'd0);
        check_pattern("bitmap_bg", char_w[3:0]);
        set_mode(1'b1, 1'b0, 1'b0);
        check_pattern("ecm_bg", bg_col[char_w[7:6]]);
        set_mode(1'b1, 1'b0, 1'b1);
        set_pattern(8'h3C, char_w, 16'd0);
        check_pattern("illegal_5", `BLACK);

        // multicolour needs char bit 11
        set_mode(1'b0, 1'b0, 1'b1);
        set_pattern(8'h55, char_w | 12'h800, 16'd0);
        check_pattern("mc_char_01", bg_col[1]);
        set_pattern(8'hAA, char_w | 12'h800, 16'd0);
        check_pattern("mc_char_10", bg_col[2]);
        set_pattern(8'h00, char_w | 12'h800, 16'd0);
        check_pattern("mc_char_00", bg_col[0]);

        set_mode(1'b0, 1'b0, 1'b0);
        set_pattern(8'h00, char_w, sprite_pair(3, 2'b10));
        check_pattern("sprite_hires", spr_col[3]);
        set_pattern(8'h00, char_w, sprite_pair(2, 2'b10) | sprite_pair(5, 2'b10));
        check_pattern("sprite_front", spr_col[2]);
        write_reg(`REG_SPR_MMC, 8'h08);
        set_pattern(8'h00, char_w, sprite_pair(3, 2'b01));
        check_pattern("sprite_mc", mm0_col);
        write_reg(`REG_SPR_MMC, 8'h00);
        write_reg(`REG_SPR_PRI, 8'h08);
        set_pattern(8'hFF, char_w, sprite_pair(3, 2'b10));
        check_pattern("sprite_behind", char_w[11:8]);

        if (checks == 0) begin
            errors++;
            $display("no pixel was compared during the test windows");
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/vic_pkg.sv
logic/dot_timing.sv
logic/color_regs.sv
logic/phase_delay.sv
logic/sprite_priority.sv
logic/pixel_sequencer.sv
logic/vic_pixel_top.sv
tests/tb_vic_pixel.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run into sim.log and look for the pass line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_vic_pixel -o tb_vic_pixel \
    && ./obj_dir/tb_vic_pixel > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q "^=== PASS ===$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
